//--- include/rob_defs_defs.svh
// sizing macros for the reorder buffer, included by the package and every RTL stage
`ifndef ROB_DEFS_DEFS_SVH
`define ROB_DEFS_DEFS_SVH

// ==================================================
// buffer geometry
// ==================================================
`define ROB_DEPTH     16
// pointers carry one extra wrap bit above this
`define ROB_IDX_W     4

// ==================================================
// lane counts
// ==================================================
`define DECODE_WIDTH  2
`define COMMIT_WIDTH  2
`define ALU_PORTS     2

// ==================================================
// payload field widths
// ==================================================
`define PC_W          32
`define AREG_W        5
`define PREG_W        6
`define ECODE_W       6

`endif

//--- src/rob_pkg.sv
// shared types for the reorder buffer, referenced by scoped name from every RTL stage
`default_nettype none
`include "rob_defs_defs.svh"

package rob_pkg;

  // instruction class recorded at allocation
  typedef enum logic [2:0] {
    INSTR_ALU    = 3'd0,
    INSTR_BRANCH = 3'd1,
    INSTR_LOAD   = 3'd2,
    INSTR_STORE  = 3'd3,
    INSTR_ATOMIC = 3'd4
  } instr_type_e;

  // one stored buffer entry
  typedef struct packed {
    logic                complete;
    instr_type_e         instr_type;
    logic [`PC_W-1:0]    pc;
    // rename state released at commit
    logic [`AREG_W-1:0]  arch_reg;
    logic [`PREG_W-1:0]  phy_reg;
    logic [`PREG_W-1:0]  old_phy_reg;
    logic                old_phy_reg_valid;
    logic                excp_valid;
    logic [`ECODE_W-1:0] ecode;
    // branch resolution from the ALU
    logic                br_redirect;
    logic [`PC_W-1:0]    br_target;
  } rob_entry_t;

endpackage

`default_nettype wire

//--- src/rob_alloc.sv
// allocation stage of the reorder buffer: tail pointer, ready level and per-lane slots
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs_defs.svh"

module rob_alloc (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush,
  input  logic [`DECODE_WIDTH-1:0]                  alloc_valid,
  input  logic [`ROB_IDX_W:0]                       head_ptr,
  output logic                                      alloc_ready,
  output logic [`DECODE_WIDTH-1:0][`ROB_IDX_W-1:0]  alloc_rob_idx,
  output logic [`DECODE_WIDTH-1:0]                  alloc_wrap,
  output logic [`DECODE_WIDTH-1:0]                  alloc_fire,
  output logic [`DECODE_WIDTH-1:0][`ROB_IDX_W-1:0]  alloc_slot,
  output logic [`ROB_IDX_W:0]                       tail_ptr
);

  localparam int PTR_W = `ROB_IDX_W + 1;
  localparam int CNT_W = $clog2(`DECODE_WIDTH) + 1;

  logic [PTR_W-1:0]                     occupancy;
  logic [CNT_W-1:0]                     alloc_cnt;
  logic [`DECODE_WIDTH-1:0][PTR_W-1:0]  lane_ptr;

  // ==================================================
  // occupancy and ready
  // ==================================================
  // wrap bit makes the difference exact from 0 to ROB_DEPTH
  assign occupancy   = tail_ptr - head_ptr;
  assign alloc_ready = occupancy <= PTR_W'(`ROB_DEPTH - `DECODE_WIDTH);

  // ==================================================
  // lane slots
  // ==================================================
  // each lane skips past the valid lanes below it
  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      lane_ptr[i] = tail_ptr + PTR_W'(alloc_cnt);
      alloc_cnt   = alloc_cnt + CNT_W'(alloc_valid[i]);
    end
  end

  for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : gen_lane
    assign alloc_fire[i]    = alloc_ready & alloc_valid[i];
    assign alloc_slot[i]    = lane_ptr[i][`ROB_IDX_W-1:0];
    assign alloc_rob_idx[i] = lane_ptr[i][`ROB_IDX_W-1:0];
    assign alloc_wrap[i]    = lane_ptr[i][`ROB_IDX_W];
  end

  // tail moves by the number of accepted lanes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_ptr <= '0;
    end else if (flush) begin
      tail_ptr <= '0;
    end else if (alloc_ready) begin
      tail_ptr <= tail_ptr + PTR_W'(alloc_cnt);
    end
  end

endmodule

`default_nettype wire

//--- src/rob_entry_store.sv
// entry array of the reorder buffer: allocation writes, write-back completion, memory gating
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs_defs.svh"

module rob_entry_store (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          flush,
  // allocation writes
  input  logic [`DECODE_WIDTH-1:0]                      alloc_fire,
  input  logic [`DECODE_WIDTH-1:0][`ROB_IDX_W-1:0]      alloc_slot,
  input  logic [`DECODE_WIDTH-1:0][`PC_W-1:0]           alloc_pc,
  input  rob_pkg::instr_type_e [`DECODE_WIDTH-1:0]      alloc_instr_type,
  input  logic [`DECODE_WIDTH-1:0][`AREG_W-1:0]         alloc_arch_reg,
  input  logic [`DECODE_WIDTH-1:0][`PREG_W-1:0]         alloc_phy_reg,
  input  logic [`DECODE_WIDTH-1:0][`PREG_W-1:0]         alloc_old_phy_reg,
  input  logic [`DECODE_WIDTH-1:0]                      alloc_old_phy_reg_valid,
  input  logic [`DECODE_WIDTH-1:0]                      alloc_excp_valid,
  input  logic [`DECODE_WIDTH-1:0][`ECODE_W-1:0]        alloc_ecode,
  // ALU write-back
  input  logic [`ALU_PORTS-1:0]                         alu_wb_valid,
  input  logic [`ALU_PORTS-1:0][`ROB_IDX_W-1:0]         alu_wb_idx,
  input  logic [`ALU_PORTS-1:0]                         alu_wb_redirect,
  input  logic [`ALU_PORTS-1:0][`PC_W-1:0]              alu_wb_target,
  // memory write-back
  input  logic                                          mem_wb_valid,
  input  logic [`ROB_IDX_W-1:0]                         mem_wb_idx,
  input  logic                                          mem_wb_excp_valid,
  input  logic [`ECODE_W-1:0]                           mem_wb_ecode,
  output logic                                          mem_wb_ready,
  // head side
  input  logic [`ROB_IDX_W:0]                           head_ptr,
  output rob_pkg::rob_entry_t                           head_entry,
  output rob_pkg::rob_entry_t                           next_entry
);

  rob_pkg::rob_entry_t       entries_q [`ROB_DEPTH];
  rob_pkg::rob_entry_t       entries_n [`ROB_DEPTH];
  logic [`ROB_IDX_W-1:0]     head_idx;
  logic [`ROB_IDX_W-1:0]     next_idx;

  assign head_idx = head_ptr[`ROB_IDX_W-1:0];
  assign next_idx = head_idx + 1'b1;

  // loads complete any time, stores and atomics only once oldest
  assign mem_wb_ready = (entries_q[mem_wb_idx].instr_type == rob_pkg::INSTR_LOAD) ||
                        (mem_wb_idx == head_idx);

  // ==================================================
  // next-state of the array
  // ==================================================
  always_comb begin
    entries_n = entries_q;

    // allocation, an excepting entry is born complete
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      if (alloc_fire[i]) begin
        entries_n[alloc_slot[i]]                   = '0;
        entries_n[alloc_slot[i]].complete          = alloc_excp_valid[i];
        entries_n[alloc_slot[i]].instr_type        = alloc_instr_type[i];
        entries_n[alloc_slot[i]].pc                = alloc_pc[i];
        entries_n[alloc_slot[i]].arch_reg          = alloc_arch_reg[i];
        entries_n[alloc_slot[i]].phy_reg           = alloc_phy_reg[i];
        entries_n[alloc_slot[i]].old_phy_reg       = alloc_old_phy_reg[i];
        entries_n[alloc_slot[i]].old_phy_reg_valid = alloc_old_phy_reg_valid[i];
        entries_n[alloc_slot[i]].excp_valid        = alloc_excp_valid[i];
        entries_n[alloc_slot[i]].ecode             = alloc_ecode[i];
      end
    end

    // ALU ports also resolve branches
    for (int p = 0; p < `ALU_PORTS; p++) begin
      if (alu_wb_valid[p]) begin
        entries_n[alu_wb_idx[p]].complete    = 1'b1;
        entries_n[alu_wb_idx[p]].br_redirect = alu_wb_redirect[p];
        entries_n[alu_wb_idx[p]].br_target   = alu_wb_target[p];
      end
    end

    if (mem_wb_valid && mem_wb_ready) begin
      entries_n[mem_wb_idx].complete   = 1'b1;
      entries_n[mem_wb_idx].excp_valid = mem_wb_excp_valid;
      entries_n[mem_wb_idx].ecode      = mem_wb_ecode;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      entries_q <= '{default: '0};
    end else if (flush) begin
      entries_q <= '{default: '0};
    end else begin
      entries_q <= entries_n;
    end
  end

  // oldest two entries for the commit stage
  assign head_entry = entries_q[head_idx];
  assign next_entry = entries_q[next_idx];

endmodule

`default_nettype wire

//--- src/rob_commit.sv
// commit stage of the reorder buffer: head pointer, commit masks and in-order retire outputs
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs_defs.svh"

module rob_commit (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        flush,
  input  logic [`ROB_IDX_W:0]                         tail_ptr,
  input  rob_pkg::rob_entry_t                         head_entry,
  input  rob_pkg::rob_entry_t                         next_entry,
  output logic [`ROB_IDX_W:0]                         head_ptr,
  output logic [`COMMIT_WIDTH-1:0]                    commit_valid,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]         commit_pc,
  output logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]       commit_arch_reg,
  output logic [`COMMIT_WIDTH-1:0][`PREG_W-1:0]       commit_phy_reg,
  output logic [`COMMIT_WIDTH-1:0][`PREG_W-1:0]       commit_old_phy_reg,
  output logic [`COMMIT_WIDTH-1:0]                    commit_old_phy_reg_valid,
  output logic [`COMMIT_WIDTH-1:0]                    commit_excp_valid,
  output logic [`COMMIT_WIDTH-1:0][`ECODE_W-1:0]      commit_ecode,
  output logic [`COMMIT_WIDTH-1:0]                    commit_redirect,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]         commit_target
);

  localparam int PTR_W = `ROB_IDX_W + 1;
  localparam int CNT_W = $clog2(`COMMIT_WIDTH) + 1;

  rob_pkg::rob_entry_t         lane_entry [`COMMIT_WIDTH];
  logic [PTR_W-1:0]            occupancy;
  logic [CNT_W-1:0]            commit_cnt;
  logic [`COMMIT_WIDTH-1:0]    valid_mask;
  logic                        redirect_mask;
  logic                        exc_mask;
  logic                        br_mask;
  logic                        commit_mask;

  assign lane_entry[0] = head_entry;
  assign lane_entry[1] = next_entry;
  assign occupancy     = tail_ptr - head_ptr;

  // ==================================================
  // commit masks
  // ==================================================
  // masks gate lane 1 only
  // redirect or exception drains the pipe, nothing retires behind it
  assign redirect_mask = ~head_entry.br_redirect & ~next_entry.br_redirect;
  assign exc_mask      = ~head_entry.excp_valid & ~next_entry.excp_valid;
  // one branch per cycle for the predictor update
  assign br_mask       = head_entry.instr_type != rob_pkg::INSTR_BRANCH;

  assign commit_mask = redirect_mask & exc_mask & br_mask;

  for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : gen_valid
    assign valid_mask[i] = occupancy > PTR_W'(i);
  end

  assign commit_valid[0] = valid_mask[0] & head_entry.complete;
  assign commit_valid[1] = commit_valid[0] & valid_mask[1] & next_entry.complete &
                           commit_mask;

  // ==================================================
  // retire outputs and head advance
  // ==================================================
  for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : gen_lane
    assign commit_pc[i]                = lane_entry[i].pc;
    assign commit_arch_reg[i]          = lane_entry[i].arch_reg;
    assign commit_phy_reg[i]           = lane_entry[i].phy_reg;
    assign commit_old_phy_reg[i]       = lane_entry[i].old_phy_reg;
    assign commit_old_phy_reg_valid[i] = lane_entry[i].old_phy_reg_valid;
    assign commit_excp_valid[i]        = lane_entry[i].excp_valid;
    assign commit_ecode[i]             = lane_entry[i].ecode;
    assign commit_redirect[i]          = lane_entry[i].br_redirect;
    assign commit_target[i]            = lane_entry[i].br_target;
  end

  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      commit_cnt = commit_cnt + CNT_W'(commit_valid[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
    end else if (flush) begin
      head_ptr <= '0;
    end else begin
      head_ptr <= head_ptr + PTR_W'(commit_cnt);
    end
  end

endmodule

`default_nettype wire

//--- src/rob_top.sv
// top level of the two-wide reorder buffer, connecting allocation, entry store and commit
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs_defs.svh"

module rob_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          flush,
  // allocation
  input  logic [`DECODE_WIDTH-1:0]                      alloc_valid,
  input  logic [`DECODE_WIDTH-1:0][`PC_W-1:0]           alloc_pc,
  input  rob_pkg::instr_type_e [`DECODE_WIDTH-1:0]      alloc_instr_type,
  input  logic [`DECODE_WIDTH-1:0][`AREG_W-1:0]         alloc_arch_reg,
  input  logic [`DECODE_WIDTH-1:0][`PREG_W-1:0]         alloc_phy_reg,
  input  logic [`DECODE_WIDTH-1:0][`PREG_W-1:0]         alloc_old_phy_reg,
  input  logic [`DECODE_WIDTH-1:0]                      alloc_old_phy_reg_valid,
  input  logic [`DECODE_WIDTH-1:0]                      alloc_excp_valid,
  input  logic [`DECODE_WIDTH-1:0][`ECODE_W-1:0]        alloc_ecode,
  output logic                                          alloc_ready,
  output logic [`DECODE_WIDTH-1:0][`ROB_IDX_W-1:0]      alloc_rob_idx,
  output logic [`DECODE_WIDTH-1:0]                      alloc_wrap,
  // ALU write-back
  input  logic [`ALU_PORTS-1:0]                         alu_wb_valid,
  input  logic [`ALU_PORTS-1:0][`ROB_IDX_W-1:0]         alu_wb_idx,
  input  logic [`ALU_PORTS-1:0]                         alu_wb_redirect,
  input  logic [`ALU_PORTS-1:0][`PC_W-1:0]              alu_wb_target,
  // memory write-back
  input  logic                                          mem_wb_valid,
  input  logic [`ROB_IDX_W-1:0]                         mem_wb_idx,
  input  logic                                          mem_wb_excp_valid,
  input  logic [`ECODE_W-1:0]                           mem_wb_ecode,
  output logic                                          mem_wb_ready,
  // commit
  output logic [`COMMIT_WIDTH-1:0]                      commit_valid,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]           commit_pc,
  output logic [`COMMIT_WIDTH-1:0][`AREG_W-1:0]         commit_arch_reg,
  output logic [`COMMIT_WIDTH-1:0][`PREG_W-1:0]         commit_phy_reg,
  output logic [`COMMIT_WIDTH-1:0][`PREG_W-1:0]         commit_old_phy_reg,
  output logic [`COMMIT_WIDTH-1:0]                      commit_old_phy_reg_valid,
  output logic [`COMMIT_WIDTH-1:0]                      commit_excp_valid,
  output logic [`COMMIT_WIDTH-1:0][`ECODE_W-1:0]        commit_ecode,
  output logic [`COMMIT_WIDTH-1:0]                      commit_redirect,
  output logic [`COMMIT_WIDTH-1:0][`PC_W-1:0]           commit_target
);

  logic [`DECODE_WIDTH-1:0]                  alloc_fire;
  logic [`DECODE_WIDTH-1:0][`ROB_IDX_W-1:0]  alloc_slot;
  logic [`ROB_IDX_W:0]                       tail_ptr;
  logic [`ROB_IDX_W:0]                       head_ptr;
  rob_pkg::rob_entry_t                       head_entry;
  rob_pkg::rob_entry_t                       next_entry;

  rob_alloc u_alloc (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .alloc_valid   (alloc_valid),
    .head_ptr      (head_ptr),
    .alloc_ready   (alloc_ready),
    .alloc_rob_idx (alloc_rob_idx),
    .alloc_wrap    (alloc_wrap),
    .alloc_fire    (alloc_fire),
    .alloc_slot    (alloc_slot),
    .tail_ptr      (tail_ptr)
  );

  rob_entry_store u_store (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .flush                   (flush),
    .alloc_fire              (alloc_fire),
    .alloc_slot              (alloc_slot),
    .alloc_pc                (alloc_pc),
    .alloc_instr_type        (alloc_instr_type),
    .alloc_arch_reg          (alloc_arch_reg),
    .alloc_phy_reg           (alloc_phy_reg),
    .alloc_old_phy_reg       (alloc_old_phy_reg),
    .alloc_old_phy_reg_valid (alloc_old_phy_reg_valid),
    .alloc_excp_valid        (alloc_excp_valid),
    .alloc_ecode             (alloc_ecode),
    .alu_wb_valid            (alu_wb_valid),
    .alu_wb_idx              (alu_wb_idx),
    .alu_wb_redirect         (alu_wb_redirect),
    .alu_wb_target           (alu_wb_target),
    .mem_wb_valid            (mem_wb_valid),
    .mem_wb_idx              (mem_wb_idx),
    .mem_wb_excp_valid       (mem_wb_excp_valid),
    .mem_wb_ecode            (mem_wb_ecode),
    .mem_wb_ready            (mem_wb_ready),
    .head_ptr                (head_ptr),
    .head_entry              (head_entry),
    .next_entry              (next_entry)
  );

  rob_commit u_commit (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .flush                    (flush),
    .tail_ptr                 (tail_ptr),
    .head_entry               (head_entry),
    .next_entry               (next_entry),
    .head_ptr                 (head_ptr),
    .commit_valid             (commit_valid),
    .commit_pc                (commit_pc),
    .commit_arch_reg          (commit_arch_reg),
    .commit_phy_reg           (commit_phy_reg),
    .commit_old_phy_reg       (commit_old_phy_reg),
    .commit_old_phy_reg_valid (commit_old_phy_reg_valid),
    .commit_excp_valid        (commit_excp_valid),
    .commit_ecode             (commit_ecode),
    .commit_redirect          (commit_redirect),
    .commit_target            (commit_target)
  );

endmodule

`default_nettype wire

//--- testbench/rob_tb.sv
// self-checking testbench for rob_top, run as the simulation top with the sources of the file list
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs_defs.svh"

module rob_tb;

  localparam int TEST_MAX_CYCLES = 400;
  // six tests plus reset, with generous slack
  localparam int MAX_CYCLES = 10 * TEST_MAX_CYCLES;

  logic clk = 1'b0;
  logic rst_n;
  logic flush;
  logic [1:0] alloc_valid;
  logic [1:0][`PC_W-1:0] alloc_pc;
  rob_pkg::instr_type_e [1:0] alloc_instr_type;
  logic [1:0][`AREG_W-1:0] alloc_arch_reg;
  logic [1:0][`PREG_W-1:0] alloc_phy_reg;
  logic [1:0][`PREG_W-1:0] alloc_old_phy_reg;
  logic [1:0] alloc_old_phy_reg_valid;
  logic [1:0] alloc_excp_valid;
  logic [1:0][`ECODE_W-1:0] alloc_ecode;
  logic alloc_ready;
  logic [1:0][`ROB_IDX_W-1:0] alloc_rob_idx;
  logic [1:0] alloc_wrap;
  logic [1:0] alu_wb_valid;
  logic [1:0][`ROB_IDX_W-1:0] alu_wb_idx;
  logic [1:0] alu_wb_redirect;
  logic [1:0][`PC_W-1:0] alu_wb_target;
  logic mem_wb_valid;
  logic [`ROB_IDX_W-1:0] mem_wb_idx;
  logic mem_wb_excp_valid;
  logic [`ECODE_W-1:0] mem_wb_ecode;
  logic mem_wb_ready;
  logic [1:0] commit_valid;
  logic [1:0][`PC_W-1:0] commit_pc;
  logic [1:0][`AREG_W-1:0] commit_arch_reg;
  logic [1:0][`PREG_W-1:0] commit_phy_reg;
  logic [1:0][`PREG_W-1:0] commit_old_phy_reg;
  logic [1:0] commit_old_phy_reg_valid;
  logic [1:0] commit_excp_valid;
  logic [1:0][`ECODE_W-1:0] commit_ecode;
  logic [1:0] commit_redirect;
  logic [1:0][`PC_W-1:0] commit_target;

  // mirror of the buffer
  rob_pkg::rob_entry_t m_ent [`ROB_DEPTH];
  logic [`ROB_IDX_W:0] m_head;
  logic [`ROB_IDX_W:0] m_tail;

  logic [31:0] lfsr_state = 32'h8e57a7e9;
  logic [31:0] pc_next = 32'h1000;
  string cur_test = "reset";
  int errors = 0;
  int err_start = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int cycles = 0;

  rob_top u_dut (.*);

  always #10 clk = ~clk;

  // ==================================================
  // helpers
  // ==================================================
  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // pointer difference kept at pointer width so the wrap bit resolves it
  function automatic logic [`ROB_IDX_W:0] mirror_occupancy();
    return m_tail - m_head;
  endfunction

  // expected commit lanes from the mirror
  function automatic logic [1:0] model_commit();
    logic [`ROB_IDX_W:0] occ;
    rob_pkg::rob_entry_t h;
    rob_pkg::rob_entry_t n;
    logic c0;
    logic c1;
    occ = m_tail - m_head;
    h = m_ent[m_head[`ROB_IDX_W-1:0]];
    n = m_ent[m_head[`ROB_IDX_W-1:0] + 1'b1];
    c0 = (occ >= 1) && h.complete;
    c1 = c0 && (occ >= 2) && n.complete && !h.excp_valid && !n.excp_valid &&
         !h.br_redirect && !n.br_redirect && (h.instr_type != rob_pkg::INSTR_BRANCH);
    return {c1, c0};
  endfunction

  function automatic logic model_mem_ready(input logic [`ROB_IDX_W-1:0] idx);
    return (m_ent[idx].instr_type == rob_pkg::INSTR_LOAD) || (idx == m_head[`ROB_IDX_W-1:0]);
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // ==================================================
  // mirror update at each edge, from pre-edge inputs
  // ==================================================
  always @(posedge clk or negedge rst_n) begin
    logic [1:0] cv;
    logic [`ROB_IDX_W:0] slot;
    logic mem_ok;
    if (!rst_n || flush) begin
      m_head = '0;
      m_tail = '0;
      for (int i = 0; i < `ROB_DEPTH; i++) m_ent[i] = '0;
    end else begin
      cv = model_commit();
      mem_ok = model_mem_ready(mem_wb_idx);
      if (mirror_occupancy() <= (`ROB_DEPTH - 2)) begin
        slot = m_tail;
        for (int i = 0; i < 2; i++) begin
          if (alloc_valid[i]) begin
            m_ent[slot[`ROB_IDX_W-1:0]] = '{complete: alloc_excp_valid[i],
              instr_type: alloc_instr_type[i], pc: alloc_pc[i],
              arch_reg: alloc_arch_reg[i], phy_reg: alloc_phy_reg[i],
              old_phy_reg: alloc_old_phy_reg[i], old_phy_reg_valid: alloc_old_phy_reg_valid[i],
              excp_valid: alloc_excp_valid[i], ecode: alloc_ecode[i],
              br_redirect: 1'b0, br_target: '0};
            slot = slot + 1'b1;
          end
        end
        m_tail = slot;
      end
      for (int p = 0; p < 2; p++) begin
        if (alu_wb_valid[p]) begin
          m_ent[alu_wb_idx[p]].complete = 1'b1;
          m_ent[alu_wb_idx[p]].br_redirect = alu_wb_redirect[p];
          m_ent[alu_wb_idx[p]].br_target = alu_wb_target[p];
        end
      end
      if (mem_wb_valid && mem_ok) begin
        m_ent[mem_wb_idx].complete = 1'b1;
        m_ent[mem_wb_idx].excp_valid = mem_wb_excp_valid;
        m_ent[mem_wb_idx].ecode = mem_wb_ecode;
      end
      m_head = m_head + cv[0] + cv[1];
    end
  end

  // ==================================================
  // compare at mid-cycle, outputs settled
  // ==================================================
  always @(negedge clk) begin
    logic [1:0] exp_cv;
    logic [`ROB_IDX_W:0] slot;
    rob_pkg::rob_entry_t e;
    if (rst_n) begin
      exp_cv = model_commit();
      compare_value("alloc_ready", mirror_occupancy() <= (`ROB_DEPTH - 2), alloc_ready);
      compare_value("commit_valid", exp_cv, commit_valid);
      slot = m_tail;
      for (int i = 0; i < 2; i++) begin
        if (alloc_valid[i]) begin
          compare_value("alloc_rob_idx", slot[`ROB_IDX_W-1:0], alloc_rob_idx[i]);
          compare_value("alloc_wrap", slot[`ROB_IDX_W], alloc_wrap[i]);
          slot = slot + 1'b1;
        end
      end
      if (mem_wb_valid) compare_value("mem_wb_ready", model_mem_ready(mem_wb_idx), mem_wb_ready);
      for (int i = 0; i < 2; i++) begin
        if (exp_cv[i]) begin
          e = m_ent[m_head[`ROB_IDX_W-1:0] + i[`ROB_IDX_W-1:0]];
          compare_value("commit_pc", e.pc, commit_pc[i]);
          compare_value("commit_arch_reg", e.arch_reg, commit_arch_reg[i]);
          compare_value("commit_phy_reg", e.phy_reg, commit_phy_reg[i]);
          compare_value("commit_old_phy_reg", e.old_phy_reg, commit_old_phy_reg[i]);
          compare_value("commit_old_valid", e.old_phy_reg_valid, commit_old_phy_reg_valid[i]);
          compare_value("commit_excp_valid", e.excp_valid, commit_excp_valid[i]);
          compare_value("commit_ecode", e.ecode, commit_ecode[i]);
          compare_value("commit_redirect", e.br_redirect, commit_redirect[i]);
          compare_value("commit_target", e.br_target, commit_target[i]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ==================================================
  // stimulus tasks
  // ==================================================
  task automatic issue(input logic [1:0] v, input rob_pkg::instr_type_e t0,
                       input rob_pkg::instr_type_e t1, input logic [1:0] ex,
                       output logic [3:0] i0, output logic [3:0] i1);
    logic rdy;
    @(posedge clk);
    alloc_valid <= v;
    alloc_instr_type[0] <= t0;
    alloc_instr_type[1] <= t1;
    alloc_excp_valid <= ex;
    for (int i = 0; i < 2; i++) begin
      alloc_pc[i] <= pc_next;
      pc_next = pc_next + 4;
      alloc_arch_reg[i] <= `AREG_W'(rand_bits(`AREG_W));
      alloc_phy_reg[i] <= `PREG_W'(rand_bits(`PREG_W));
      alloc_old_phy_reg[i] <= `PREG_W'(rand_bits(`PREG_W));
      alloc_old_phy_reg_valid[i] <= 1'(rand_bits(1));
      alloc_ecode[i] <= `ECODE_W'(rand_bits(`ECODE_W));
    end
    do begin
      @(negedge clk);
      rdy = alloc_ready;
      i0 = alloc_rob_idx[0];
      i1 = alloc_rob_idx[1];
      @(posedge clk);
    end while (!rdy);
    alloc_valid <= '0;
    alloc_excp_valid <= '0;
  endtask

  task automatic alu_wb(input int p, input logic [3:0] idx, input logic redir,
                        input logic [31:0] tgt);
    @(posedge clk);
    alu_wb_valid[p] <= 1'b1;
    alu_wb_idx[p] <= idx;
    alu_wb_redirect[p] <= redir;
    alu_wb_target[p] <= tgt;
    @(posedge clk);
    alu_wb_valid[p] <= 1'b0;
  endtask

  // request is held until the port is ready
  task automatic mem_wb(input logic [3:0] idx, input logic ex, output int waited);
    logic rdy;
    @(posedge clk);
    mem_wb_valid <= 1'b1;
    mem_wb_idx <= idx;
    mem_wb_excp_valid <= ex;
    mem_wb_ecode <= `ECODE_W'(rand_bits(`ECODE_W));
    waited = 0;
    forever begin
      @(negedge clk);
      rdy = mem_wb_ready;
      @(posedge clk);
      if (rdy) break;
      waited++;
    end
    mem_wb_valid <= 1'b0;
  endtask

  task automatic drain();
    do @(negedge clk); while (m_tail != m_head);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %s: %s (%0d errors)", cur_test,
             (errors == err_start) ? "pass" : "FAIL", errors - err_start);
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    logic [3:0] a;
    logic [3:0] b;
    logic [3:0] c;
    logic [3:0] d;
    logic [1:0] v;
    int waited;
    int k;
    logic [3:0] q[$];
    rst_n <= 1'b0;
    flush <= 1'b0;
    alloc_valid <= '0;
    alloc_pc <= '0;
    alloc_instr_type <= {rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU};
    alloc_arch_reg <= '0;
    alloc_phy_reg <= '0;
    alloc_old_phy_reg <= '0;
    alloc_old_phy_reg_valid <= '0;
    alloc_excp_valid <= '0;
    alloc_ecode <= '0;
    alu_wb_valid <= '0;
    alu_wb_idx <= '0;
    alu_wb_redirect <= '0;
    alu_wb_target <= '0;
    mem_wb_valid <= 1'b0;
    mem_wb_idx <= '0;
    mem_wb_excp_valid <= 1'b0;
    mem_wb_ecode <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    start_test("random_order");
    for (int r = 0; r < 6; r++) begin
      v = 2'(rand_bits(2));
      if (v == 2'b00) v = 2'b11;
      issue(v, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, a, b);
      if (v[0]) q.push_back(a);
      if (v[1]) q.push_back(v[0] ? b : a);
    end
    while (q.size() > 0) begin
      k = rand_bits(8) % q.size();
      alu_wb(k % 2, q[k], 1'b0, '0);
      q.delete(k);
    end
    drain();
    end_test();

    start_test("fill_wrap");
    for (int r = 0; r < 8; r++) begin
      issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, a, b);
      q.push_back(a);
      q.push_back(b);
    end
    @(negedge clk);
    compare_value("alloc_ready when full", 1'b0, alloc_ready);
    // one more pair waits on alloc_ready while the head drains
    fork
      issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, c, d);
      while (q.size() > 0) alu_wb(0, q.pop_front(), 1'b0, '0);
    join
    alu_wb(0, c, 1'b0, '0);
    alu_wb(1, d, 1'b0, '0);
    drain();
    end_test();

    start_test("mem_gating");
    issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_STORE, 2'b00, a, b);
    issue(2'b11, rob_pkg::INSTR_LOAD, rob_pkg::INSTR_ATOMIC, 2'b00, c, d);
    mem_wb(c, 1'b0, waited);
    if (waited != 0) begin
      errors++;
      $display("error %s: load write-back was held for %0d cycles", cur_test, waited);
    end
    fork
      mem_wb(b, 1'b0, waited);
      begin
        repeat (4) @(posedge clk);
        alu_wb(1, a, 1'b0, '0);
      end
    join
    if (waited == 0) begin
      errors++;
      $display("error %s: store write-back accepted before reaching the head", cur_test);
    end
    mem_wb(d, 1'b0, waited);
    drain();
    end_test();

    start_test("exceptions");
    // excepting lane 1 sits complete behind the head
    issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b10, a, b);
    alu_wb(0, a, 1'b0, '0);
    issue(2'b11, rob_pkg::INSTR_LOAD, rob_pkg::INSTR_ALU, 2'b00, a, b);
    alu_wb(1, b, 1'b0, '0);
    mem_wb(a, 1'b1, waited);
    drain();
    end_test();

    start_test("branches");
    issue(2'b11, rob_pkg::INSTR_BRANCH, rob_pkg::INSTR_BRANCH, 2'b00, a, b);
    alu_wb(1, b, 1'b0, 32'h2000);
    alu_wb(0, a, 1'b0, 32'h2004);
    // redirect at head+1 behind a plain head
    issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_BRANCH, 2'b00, a, b);
    alu_wb(1, b, 1'b1, rand_bits(32));
    alu_wb(0, a, 1'b0, '0);
    drain();
    end_test();

    start_test("flush");
    issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, a, b);
    issue(2'b11, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, a, b);
    alu_wb(0, a, 1'b0, '0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    repeat (2) @(posedge clk);
    issue(2'b01, rob_pkg::INSTR_ALU, rob_pkg::INSTR_ALU, 2'b00, a, b);
    if (a != 4'd0) begin
      errors++;
      $display("error %s alloc index after flush: expected 0 actual %0d", cur_test, a);
    end
    alu_wb(0, a, 1'b0, '0);
    drain();
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rob_top.f
+incdir+include
src/rob_pkg.sv
src/rob_alloc.sv
src/rob_entry_store.sv
src/rob_commit.sv
src/rob_top.sv
testbench/rob_tb.sv

//--- Bender.yml
package:
  name: rob_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/rob_pkg.sv
      - src/rob_alloc.sv
      - src/rob_entry_store.sv
      - src/rob_commit.sv
      - src/rob_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/rob_tb.sv
